// ==== verilog.f ====
+incdir+common
common/dmaPkg.sv
common/dmaIfs.sv
src/dualPortSsram.sv
ramDmaCi/ciDecoder.sv
ramDmaCi/dmaBusMaster.sv
ramDmaCi/ramDmaCi.sv
verif/busSlaveModel.sv
verif/tbRamDmaCi.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
logFile=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tbRamDmaCi -f verilog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VtbRamDmaCi > "$logFile" 2>&1
runStatus=$?
cat "$logFile"
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
fi

if grep -qx "test passed" "$logFile"; then
    exit 0
else
    exit 1
fi

// ==== verif/tbRamDmaCi.sv ====
`include "dmaConsts.svh"

module tbRamDmaCi;
    import dmaPkg::*;

    localparam ciId_t myCi = 8'h0F;
    // Each block transfer needs a few hundred cycles, the whole run a few thousand
    localparam int cycleLimit = 20000;

    logic       clock;
    logic       rst;
    logic       start;
    ciId_t      ciN;
    word_t      valueA;
    word_t      valueB;
    logic       done;
    word_t      result;
    logic       busOutRequest;
    logic       busInGrant;
    word_t      busOutAddressData;
    burstSize_t busOutBurstSize;
    logic       busOutReadNotWrite;
    logic       busOutBeginTransaction;
    logic       busOutEndTransaction;
    logic       busOutDataValid;
    word_t      busInAddressData;
    logic       busInDataValid;
    logic       busInEndTransaction;
    logic       busInBusy;
    logic       busInError;
    word_t      errorAddress;

    word_t      lfsrState;
    word_t      sramModel [`SRAM_DEPTH];
    string      testName;
    int         cycleCount = 0;

    ramDmaCi #(.customId(myCi)) u_dut (.*);

    busSlaveModel u_busSlave (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            failRun($sformatf("Timeout: the tests did not finish within %0d cycles", cycleLimit));
        end
    end

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string what, input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            failRun($sformatf("CHECK FAILED %s, %s: expected %h, actual %h",
                              testName, what, expected, actual));
        end
    endtask

    // Galois LFSR, one step per bit
    function automatic word_t randomBits(input int count);
        word_t value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
        end
        return value;
    endfunction

    function automatic word_t opcode(input logic [2:0] sel, input logic write, input sramAddr_t addr);
        return {19'd0, sel, write, addr};
    endfunction

    // Start high for one cycle, outputs sampled mid-cycle in that cycle and the next
    task automatic issue(input ciId_t id, input word_t a, input word_t b,
                         output logic doneNow, output word_t resultNow,
                         output logic doneNext, output word_t resultNext);
        @(negedge clock);
        start  = 1'b1;
        ciN    = id;
        valueA = a;
        valueB = b;
        #25;
        doneNow   = done;
        resultNow = result;
        @(negedge clock);
        start = 1'b0;
        #25;
        doneNext   = done;
        resultNext = result;
    endtask

    task automatic writeReg(input logic [2:0] sel, input sramAddr_t addr, input word_t value);
        logic  doneNow;
        logic  doneNext;
        word_t resultNow;
        word_t resultNext;
        issue(myCi, opcode(sel, 1'b1, addr), value, doneNow, resultNow, doneNext, resultNext);
        checkValue("done on write", 32'd1, {31'd0, doneNow});
        checkValue("result on write", 32'd0, resultNow);
        checkValue("done after write", 32'd0, {31'd0, doneNext});
        if (sel == `SEL_MEMORY) begin
            sramModel[addr] = value;
        end
    endtask

    task automatic readReg(input logic [2:0] sel, output word_t value);
        logic  doneNow;
        logic  doneNext;
        word_t resultNext;
        issue(myCi, opcode(sel, 1'b0, '0), '0, doneNow, value, doneNext, resultNext);
        checkValue("done on register read", 32'd1, {31'd0, doneNow});
        checkValue("done after register read", 32'd0, {31'd0, doneNext});
    endtask

    task automatic readMem(input sramAddr_t addr, output word_t value);
        logic  doneNow;
        logic  doneNext;
        word_t resultNow;
        issue(myCi, opcode(`SEL_MEMORY, 1'b0, addr), '0, doneNow, resultNow, doneNext, value);
        checkValue("done in sram read cycle", 32'd0, {31'd0, doneNow});
        checkValue("result while done low", 32'd0, resultNow);
        checkValue("done after sram read", 32'd1, {31'd0, doneNext});
    endtask

    task automatic configure(input int busIndex, input sramAddr_t memAddr,
                             input int words, input int burst);
        writeReg(`SEL_BUS_ADDR, '0, 32'h1000 + 4 * busIndex);
        writeReg(`SEL_MEM_ADDR, '0, {23'd0, memAddr});
        writeReg(`SEL_BLOCK_SIZE, '0, word_t'(words));
        writeReg(`SEL_BURST_SIZE, '0, word_t'(burst));
    endtask

    task automatic waitIdle(output word_t status);
        do begin
            readReg(`SEL_CTRL_STATUS, status);
        end while (status[0]);
    endtask

    // Full bursts of burst+1 words, the last one gets the rest
    task automatic checkBursts(input int first, input int words, input int burst);
        int left;
        int expected;
        left = words;
        checkValue("bus protocol errors", 32'd0, word_t'(u_busSlave.protocolErrors));
        checkValue("begin count", word_t'((words + burst) / (burst + 1)),
                   word_t'(u_busSlave.beginCount - first));
        for (int i = first; i < u_busSlave.beginCount; i++) begin
            expected = (left < burst + 1) ? left : burst + 1;
            checkValue("burst length", word_t'(expected), word_t'(u_busSlave.burstLog[i % 256]));
            left = left - expected;
        end
    endtask

    task automatic sramTest();
        sramAddr_t addrs [40];
        word_t     data;
        testName = "sram access";
        for (int i = 0; i < 40; i++) begin
            addrs[i] = sramAddr_t'(randomBits(9));
            writeReg(`SEL_MEMORY, addrs[i], randomBits(32));
        end
        for (int i = 0; i < 40; i++) begin
            readMem(addrs[i], data);
            checkValue("sram data", sramModel[addrs[i]], data);
        end
    endtask

    task automatic regTest();
        word_t regs [6];
        word_t value;
        logic  doneNow;
        logic  doneNext;
        word_t resultNow;
        word_t resultNext;
        testName = "register access";
        regs[`SEL_BUS_ADDR]   = randomBits(32);
        regs[`SEL_MEM_ADDR]   = randomBits(9);
        regs[`SEL_BLOCK_SIZE] = randomBits(10);
        regs[`SEL_BURST_SIZE] = randomBits(8);
        for (int sel = 1; sel < 5; sel++) begin
            writeReg(3'(sel), '0, regs[sel]);
        end
        for (int sel = 1; sel < 5; sel++) begin
            readReg(3'(sel), value);
            checkValue($sformatf("register %0d", sel), regs[sel], value);
        end
        readReg(`SEL_CTRL_STATUS, value);
        checkValue("status", 32'd0, value);
        // Another instruction number must be ignored
        issue(8'h0E, opcode(`SEL_BUS_ADDR, 1'b1, '0), ~regs[1], doneNow, resultNow,
              doneNext, resultNext);
        checkValue("foreign write done", 32'd0, {31'd0, doneNow | doneNext});
        issue(8'h0E, opcode(`SEL_BUS_ADDR, 1'b0, '0), '0, doneNow, resultNow,
              doneNext, resultNext);
        checkValue("foreign read done", 32'd0, {31'd0, doneNow | doneNext});
        checkValue("foreign read result", 32'd0, resultNow | resultNext);
        readReg(`SEL_BUS_ADDR, value);
        checkValue("bus address kept", regs[1], value);
    endtask

    task automatic readBlockTest();
        int        words;
        int        burst;
        int        busIndex;
        int        first;
        sramAddr_t memAddr;
        sramAddr_t addr;
        word_t     status;
        word_t     data;
        testName = "bus to sram";
        for (int round = 0; round < 3; round++) begin
            words    = 1 + int'(randomBits(6));
            burst    = int'(randomBits(4));
            busIndex = int'(randomBits(8));
            memAddr  = sramAddr_t'(randomBits(9));
            configure(busIndex, memAddr, words, burst);
            first = u_busSlave.beginCount;
            writeReg(`SEL_CTRL_STATUS, '0, word_t'(`CTRL_READ_BLOCK));
            waitIdle(status);
            checkValue("status", 32'd0, status);
            checkBursts(first, words, burst);
            for (int i = 0; i < words; i++) begin
                addr = memAddr + sramAddr_t'(i);
                sramModel[addr] = u_busSlave.mem[busIndex + i];
                readMem(addr, data);
                checkValue("sram word", sramModel[addr], data);
            end
        end
    endtask

    task automatic writeBlockTest();
        int        words;
        int        burst;
        int        busIndex;
        int        first;
        sramAddr_t memAddr;
        sramAddr_t addr;
        word_t     status;
        testName = "sram to bus";
        for (int round = 0; round < 3; round++) begin
            words    = 20 + int'(randomBits(5));
            burst    = int'(randomBits(4));
            busIndex = int'(randomBits(8));
            // Start near the top so the block wraps
            memAddr  = sramAddr_t'(496 + randomBits(4));
            for (int i = 0; i < words; i++) begin
                writeReg(`SEL_MEMORY, memAddr + sramAddr_t'(i), randomBits(32));
            end
            configure(busIndex, memAddr, words, burst);
            first = u_busSlave.beginCount;
            writeReg(`SEL_CTRL_STATUS, '0, word_t'(`CTRL_WRITE_BLOCK));
            waitIdle(status);
            checkValue("status", 32'd0, status);
            checkBursts(first, words, burst);
            for (int i = 0; i < words; i++) begin
                addr = memAddr + sramAddr_t'(i);
                checkValue("bus word", sramModel[addr], u_busSlave.mem[busIndex + i]);
            end
        end
    endtask

    task automatic errorTest();
        int    words;
        int    burst;
        int    busIndex;
        int    errWord;
        int    first;
        word_t status;
        logic  doneNow;
        logic  doneNext;
        word_t resultNow;
        word_t resultNext;
        logic  startSeen;
        testName = "bus error";
        words    = 16 + int'(randomBits(5));
        burst    = int'(randomBits(3));
        busIndex = int'(randomBits(8));
        errWord  = int'(randomBits(4));
        errorAddress = 32'h1000 + 4 * (busIndex + errWord);
        configure(busIndex, sramAddr_t'(randomBits(9)), words, burst);
        first = u_busSlave.beginCount;
        writeReg(`SEL_CTRL_STATUS, '0, word_t'(`CTRL_READ_BLOCK));
        // Engine is busy now, so this start must be dropped
        issue(myCi, opcode(`SEL_CTRL_STATUS, 1'b1, '0), word_t'(`CTRL_WRITE_BLOCK),
              doneNow, resultNow, doneNext, resultNext);
        startSeen = u_dut.ctrlBus.startWrite;
        checkValue("done on write while busy", 32'd1, {31'd0, doneNow});
        checkValue("start pulse while busy", 32'd0, {31'd0, startSeen});
        waitIdle(status);
        checkValue("status after abort", 32'd2, status);
        checkValue("bursts up to error", word_t'(errWord / (burst + 1) + 1),
                   word_t'(u_busSlave.beginCount - first));
        repeat (20) @(negedge clock);
        readReg(`SEL_CTRL_STATUS, status);
        checkValue("status later", 32'd2, status);
        checkValue("no further bursts", word_t'(errWord / (burst + 1) + 1),
                   word_t'(u_busSlave.beginCount - first));
    endtask

    initial begin
        lfsrState    = 32'd99832;
        rst          = 1'b1;
        start        = 1'b0;
        ciN          = '0;
        valueA       = '0;
        valueB       = '0;
        errorAddress = 32'hFFFF_FFF0;
        testName     = "reset";
        repeat (16) @(negedge clock);
        rst = 1'b0;
        sramTest();
        regTest();
        readBlockTest();
        writeBlockTest();
        errorTest();
        $display("test passed");
        $finish;
    end

endmodule

// ==== verif/busSlaveModel.sv ====
module busSlaveModel #(
    parameter logic [31:0] seed = 32'd99832
) (
    input  logic               clock,
    input  logic               rst,
    input  dmaPkg::word_t      errorAddress,
    input  logic               busOutRequest,
    output logic               busInGrant,
    input  dmaPkg::word_t      busOutAddressData,
    input  dmaPkg::burstSize_t busOutBurstSize,
    input  logic               busOutReadNotWrite,
    input  logic               busOutBeginTransaction,
    input  logic               busOutEndTransaction,
    input  logic               busOutDataValid,
    output dmaPkg::word_t      busInAddressData,
    output logic               busInDataValid,
    output logic               busInEndTransaction,
    output logic               busInBusy,
    output logic               busInError
);
    import dmaPkg::*;

    typedef enum logic [2:0] {
        slaveIdle,
        slaveWaitGrant,
        slaveGranted,
        slaveReading,
        slaveWriting,
        slaveEnding
    } phase_t;

    // Word i sits at bus address 0x1000 + 4*i
    word_t  mem [1024];
    int     beginCount;
    int     burstLog [256];
    int     protocolErrors;
    phase_t phase;
    word_t  stallState;
    word_t  address;
    word_t  offset;
    int     beatsLeft;
    int     grantDelay;

    function automatic word_t stallBits(input int count);
        word_t value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], stallState[0]};
            stallState = stallState[0] ? ((stallState >> 1) ^ 32'h80200003) : (stallState >> 1);
        end
        return value;
    endfunction

    initial begin
        busInGrant          = 1'b0;
        busInAddressData    = '0;
        busInDataValid      = 1'b0;
        busInEndTransaction = 1'b0;
        busInBusy           = 1'b0;
        busInError          = 1'b0;
    end

    // Outputs change on the falling edge, the DUT samples them on the rising one
    always @(negedge clock) begin
        busInGrant          = 1'b0;
        busInAddressData    = '0;
        busInDataValid      = 1'b0;
        busInEndTransaction = 1'b0;
        busInBusy           = 1'b0;
        busInError          = 1'b0;
        offset              = (address - 32'h1000) >> 2;
        if (rst) begin
            for (int i = 0; i < 1024; i++) begin
                mem[i] = word_t'(i) * 32'h9E3779B1 + 32'h1000;
            end
            beginCount     = 0;
            protocolErrors = 0;
            phase          = slaveIdle;
            stallState     = seed;
            address        = '0;
            beatsLeft      = 0;
            grantDelay     = 0;
        end else begin
            if ((phase == slaveIdle) && busOutRequest) begin
                grantDelay = int'(stallBits(2));
                phase      = slaveWaitGrant;
            end
            case (phase)
                slaveWaitGrant: begin
                    if (grantDelay == 0) begin
                        busInGrant = 1'b1;
                        phase      = slaveGranted;
                    end else begin
                        grantDelay = grantDelay - 1;
                    end
                end
                slaveGranted: begin
                    if (busOutBeginTransaction) begin
                        burstLog[beginCount % 256] = int'(busOutBurstSize) + 1;
                        beginCount = beginCount + 1;
                        address    = busOutAddressData;
                        beatsLeft  = int'(busOutBurstSize) + 1;
                        phase      = busOutReadNotWrite ? slaveReading : slaveWriting;
                    end else begin
                        protocolErrors = protocolErrors + 1;
                        phase          = slaveIdle;
                    end
                end
                slaveReading: begin
                    if (address == errorAddress) begin
                        busInError = 1'b1;
                        phase      = slaveIdle;
                    end else if (stallBits(2) != '0) begin
                        busInDataValid   = 1'b1;
                        busInAddressData = mem[offset[9:0]];
                        address          = address + 32'd4;
                        beatsLeft        = beatsLeft - 1;
                        if (beatsLeft == 0) begin
                            busInEndTransaction = 1'b1;
                            phase               = slaveIdle;
                        end
                    end
                end
                slaveWriting: begin
                    if (!busOutDataValid) begin
                        protocolErrors = protocolErrors + 1;
                        phase          = slaveIdle;
                    end else if (address == errorAddress) begin
                        busInError = 1'b1;
                        phase      = slaveIdle;
                    end else if (stallBits(2) == '0) begin
                        busInBusy = 1'b1;
                    end else begin
                        // Beat is taken on the coming rising edge
                        mem[offset[9:0]] = busOutAddressData;
                        address          = address + 32'd4;
                        beatsLeft        = beatsLeft - 1;
                        if (beatsLeft == 0) begin
                            phase = slaveEnding;
                        end
                    end
                end
                slaveEnding: begin
                    if (!busOutEndTransaction || busOutDataValid) begin
                        protocolErrors = protocolErrors + 1;
                    end
                    phase = slaveIdle;
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== ramDmaCi/ramDmaCi.sv ====
module ramDmaCi #(
    parameter dmaPkg::ciId_t customId = 8'h00
) (
    input  logic                clock,
    input  logic                rst,
    input  logic                start,
    input  dmaPkg::ciId_t       ciN,
    input  dmaPkg::word_t       valueA,
    input  dmaPkg::word_t       valueB,
    output logic                done,
    output dmaPkg::word_t       result,

    output logic                busOutRequest,
    input  logic                busInGrant,

    output dmaPkg::word_t       busOutAddressData,
    output dmaPkg::burstSize_t  busOutBurstSize,
    output logic                busOutReadNotWrite,
    output logic                busOutBeginTransaction,
    output logic                busOutEndTransaction,
    output logic                busOutDataValid,

    input  dmaPkg::word_t       busInAddressData,
    input  logic                busInDataValid,
    input  logic                busInEndTransaction,
    input  logic                busInBusy,
    input  logic                busInError
);

    dmaCtrlIf  ctrlBus ();
    sramPortIf portA ();
    sramPortIf portB ();

    ciDecoder #(
        .customId (customId)
    ) u_decoder (
        .clock  (clock),
        .rst    (rst),
        .start  (start),
        .ciN    (ciN),
        .valueA (valueA),
        .valueB (valueB),
        .done   (done),
        .result (result),
        .ctrl   (ctrlBus.regs),
        .sram   (portA.user)
    );

    dualPortSsram u_sram (
        .clock (clock),
        .portA (portA.memory),
        .portB (portB.memory)
    );

    dmaBusMaster u_busMaster (
        .clock                  (clock),
        .rst                    (rst),
        .ctrl                   (ctrlBus.engine),
        .sram                   (portB.user),
        .busOutRequest          (busOutRequest),
        .busInGrant             (busInGrant),
        .busOutAddressData      (busOutAddressData),
        .busOutBurstSize        (busOutBurstSize),
        .busOutReadNotWrite     (busOutReadNotWrite),
        .busOutBeginTransaction (busOutBeginTransaction),
        .busOutEndTransaction   (busOutEndTransaction),
        .busOutDataValid        (busOutDataValid),
        .busInAddressData       (busInAddressData),
        .busInDataValid         (busInDataValid),
        .busInEndTransaction    (busInEndTransaction),
        .busInBusy              (busInBusy),
        .busInError             (busInError)
    );

endmodule

// ==== ramDmaCi/dmaBusMaster.sv ====
module dmaBusMaster (
    input  logic               clock,
    input  logic               rst,
    dmaCtrlIf.engine           ctrl,
    sramPortIf.user            sram,

    output logic               busOutRequest,
    input  logic               busInGrant,

    output dmaPkg::word_t      busOutAddressData,
    output dmaPkg::burstSize_t busOutBurstSize,
    output logic               busOutReadNotWrite,
    output logic               busOutBeginTransaction,
    output logic               busOutEndTransaction,
    output logic               busOutDataValid,

    input  dmaPkg::word_t      busInAddressData,
    input  logic               busInDataValid,
    input  logic               busInEndTransaction,
    input  logic               busInBusy,
    input  logic               busInError
);
    import dmaPkg::*;

    dmaState_t  state;
    logic       isRead;
    logic       error;
    blockSize_t wordsLeft;
    blockSize_t beatsLeft;
    blockSize_t burstLength;
    blockSize_t nextBurst;
    blockSize_t beatsMinusOne;
    word_t      busAddress;
    sramAddr_t  memAddress;
    logic       beatTaken;
    logic       lastBeat;

    // Last burst of a block only carries what remains
    assign nextBurst     = (wordsLeft < burstLength) ? wordsLeft : burstLength;
    assign beatsMinusOne = beatsLeft - 1'b1;
    assign lastBeat      = (beatsLeft == 10'd1);

    // Read beats land on valid, write beats are taken when the slave is not busy
    assign beatTaken = ((state == READ_DATA) && busInDataValid)
                    || ((state == WRITE_DATA) && !busInBusy);

    always_ff @(posedge clock) begin
        if (rst) begin
            state       <= IDLE;
            isRead      <= 1'b0;
            error       <= 1'b0;
            wordsLeft   <= '0;
            beatsLeft   <= '0;
            burstLength <= '0;
            busAddress  <= '0;
            memAddress  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (ctrl.startRead || ctrl.startWrite) begin
                        isRead      <= ctrl.startRead;
                        error       <= 1'b0;
                        wordsLeft   <= ctrl.blockSize;
                        burstLength <= {2'b00, ctrl.burstSize} + 10'd1;
                        busAddress  <= ctrl.busStartAddress;
                        memAddress  <= ctrl.memStartAddress;
                        state       <= (ctrl.blockSize == '0) ? DONE : REQUEST;
                    end
                end
                REQUEST: begin
                    if (busInGrant) begin
                        beatsLeft <= nextBurst;
                        state     <= BEGIN;
                    end
                end
                BEGIN: begin
                    state <= isRead ? READ_DATA : WRITE_DATA;
                end
                READ_DATA: begin
                    if ((busInDataValid && lastBeat) || busInEndTransaction) begin
                        state <= END_BURST;
                    end
                end
                WRITE_DATA: begin
                    if (!busInBusy && lastBeat) begin
                        state <= END_BURST;
                    end
                end
                END_BURST: begin
                    state <= (wordsLeft == '0) ? DONE : REQUEST;
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase

            if (beatTaken) begin
                wordsLeft  <= wordsLeft - 1'b1;
                beatsLeft  <= beatsLeft - 1'b1;
                busAddress <= busAddress + 32'd4;
                memAddress <= memAddress + 1'b1;
            end

            // Abort the whole block
            if (busInError && (state != IDLE) && (state != DONE)) begin
                error <= 1'b1;
                state <= IDLE;
            end
        end
    end

    // Look one word ahead on writes so a beat can go out every cycle
    always_comb begin
        if ((state == WRITE_DATA) && !busInBusy) begin
            sram.address = memAddress + 1'b1;
        end else begin
            sram.address = memAddress;
        end
    end

    assign sram.writeEnable = (state == READ_DATA) && busInDataValid;
    assign sram.dataIn      = busInAddressData;

    always_comb begin
        busOutRequest          = (state == REQUEST) || (state == BEGIN)
                              || (state == READ_DATA) || (state == WRITE_DATA);
        busOutBeginTransaction = (state == BEGIN);
        busOutReadNotWrite     = (state == BEGIN) && isRead;
        busOutDataValid        = (state == WRITE_DATA);
        busOutEndTransaction   = (state == END_BURST) && !isRead;
        busOutBurstSize        = '0;
        busOutAddressData      = '0;
        if (state == BEGIN) begin
            busOutBurstSize   = beatsMinusOne[7:0];
            busOutAddressData = busAddress;
        end else if (state == WRITE_DATA) begin
            busOutAddressData = sram.dataOut;
        end
    end

    assign ctrl.busy  = (state != IDLE);
    assign ctrl.error = error;

endmodule

// ==== ramDmaCi/ciDecoder.sv ====
`include "dmaConsts.svh"

module ciDecoder #(
    parameter dmaPkg::ciId_t customId = 8'h00
) (
    input  logic          clock,
    input  logic          rst,
    input  logic          start,
    input  dmaPkg::ciId_t ciN,
    input  dmaPkg::word_t valueA,
    input  dmaPkg::word_t valueB,
    output logic          done,
    output dmaPkg::word_t result,
    dmaCtrlIf.regs        ctrl,
    sramPortIf.user       sram
);
    import dmaPkg::*;

    logic       isMyCi;
    logic [2:0] selector;
    logic       isWrite;
    logic       memAccess;
    logic       memRead;
    logic       regWrite;
    logic       immediateDone;
    logic       readPending;
    logic       engineActive;
    word_t      regValue;

    word_t      busStartAddress;
    sramAddr_t  memStartAddress;
    blockSize_t blockSize;
    burstSize_t burstSize;

    assign isMyCi    = start && (ciN == customId);
    assign selector  = valueA[12:10];
    assign isWrite   = valueA[9];
    assign memAccess = isMyCi && (selector == `SEL_MEMORY);
    assign memRead   = memAccess && !isWrite;
    assign regWrite  = isMyCi && isWrite && (selector != `SEL_MEMORY);

    // A start already issued counts as running until busy takes over
    assign engineActive = ctrl.busy || ctrl.startRead || ctrl.startWrite;

    // Port A follows the instruction directly
    assign sram.address     = valueA[`SRAM_AW-1:0];
    assign sram.writeEnable = memAccess && isWrite;
    assign sram.dataIn      = valueB;

    assign ctrl.busStartAddress = busStartAddress;
    assign ctrl.memStartAddress = memStartAddress;
    assign ctrl.blockSize       = blockSize;
    assign ctrl.burstSize       = burstSize;

    always_ff @(posedge clock) begin
        if (rst) begin
            busStartAddress <= '0;
            memStartAddress <= '0;
            blockSize       <= '0;
            burstSize       <= '0;
            ctrl.startRead  <= 1'b0;
            ctrl.startWrite <= 1'b0;
        end else begin
            ctrl.startRead  <= 1'b0;
            ctrl.startWrite <= 1'b0;
            if (regWrite) begin
                case (selector)
                    `SEL_BUS_ADDR:   busStartAddress <= valueB;
                    `SEL_MEM_ADDR:   memStartAddress <= valueB[`SRAM_AW-1:0];
                    `SEL_BLOCK_SIZE: blockSize <= valueB[9:0];
                    `SEL_BURST_SIZE: burstSize <= valueB[7:0];
                    `SEL_CTRL_STATUS: begin
                        if (!engineActive) begin
                            ctrl.startRead  <= (valueB[1:0] == `CTRL_READ_BLOCK);
                            ctrl.startWrite <= (valueB[1:0] == `CTRL_WRITE_BLOCK);
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // SRAM data is one cycle behind the request
    always_ff @(posedge clock) begin
        if (rst) begin
            readPending <= 1'b0;
        end else begin
            readPending <= memRead;
        end
    end

    always_comb begin
        case (selector)
            `SEL_BUS_ADDR:    regValue = busStartAddress;
            `SEL_MEM_ADDR:    regValue = {23'd0, memStartAddress};
            `SEL_BLOCK_SIZE:  regValue = {22'd0, blockSize};
            `SEL_BURST_SIZE:  regValue = {24'd0, burstSize};
            `SEL_CTRL_STATUS: regValue = {30'd0, ctrl.error, ctrl.busy};
            default:          regValue = '0;
        endcase
    end

    // Everything except an SRAM read completes right away
    assign immediateDone = isMyCi && !memRead;
    assign done          = readPending || immediateDone;

    always_comb begin
        if (readPending) begin
            result = sram.dataOut;
        end else if (immediateDone && !isWrite) begin
            result = regValue;
        end else begin
            result = '0;
        end
    end

endmodule

// ==== src/dualPortSsram.sv ====
`include "dmaConsts.svh"

module dualPortSsram (
    input logic       clock,
    sramPortIf.memory portA,
    sramPortIf.memory portB
);
    import dmaPkg::*;

    word_t storage [`SRAM_DEPTH];

    always_ff @(posedge clock) begin
        // Port A is applied last so it wins a same-address collision
        if (portB.writeEnable) begin
            storage[portB.address] <= portB.dataIn;
        end
        if (portA.writeEnable) begin
            storage[portA.address] <= portA.dataIn;
        end
    end

    // Registered read data, old contents on a write to the same address
    always_ff @(posedge clock) begin
        portA.dataOut <= storage[portA.address];
        portB.dataOut <= storage[portB.address];
    end

endmodule

// ==== common/dmaIfs.sv ====
// DMA configuration from the decoder to the bus engine
interface dmaCtrlIf;
    import dmaPkg::*;

    word_t      busStartAddress;
    sramAddr_t  memStartAddress;
    blockSize_t blockSize;
    burstSize_t burstSize;
    logic       startRead;
    logic       startWrite;
    logic       busy;
    logic       error;

    modport regs (
        output busStartAddress, memStartAddress, blockSize, burstSize,
        output startRead, startWrite,
        input  busy, error
    );

    modport engine (
        input  busStartAddress, memStartAddress, blockSize, burstSize,
        input  startRead, startWrite,
        output busy, error
    );
endinterface

// One SRAM port
interface sramPortIf;
    import dmaPkg::*;

    sramAddr_t address;
    logic      writeEnable;
    word_t     dataIn;
    word_t     dataOut;

    modport user (
        output address, writeEnable, dataIn,
        input  dataOut
    );

    modport memory (
        input  address, writeEnable, dataIn,
        output dataOut
    );
endinterface

// ==== common/dmaPkg.sv ====
`include "dmaConsts.svh"

package dmaPkg;

    // Data word, also used for bus addresses
    typedef logic [31:0] word_t;

    // Word address into the SRAM
    typedef logic [`SRAM_AW-1:0] sramAddr_t;

    // Number of words in a block
    typedef logic [9:0] blockSize_t;

    // Beats minus one, as sent on the bus
    typedef logic [7:0] burstSize_t;

    // Custom-instruction number
    typedef logic [7:0] ciId_t;

    // Bus master states
    typedef enum logic [2:0] {
        IDLE,
        REQUEST,
        BEGIN,
        READ_DATA,
        WRITE_DATA,
        END_BURST,
        DONE
    } dmaState_t;

endpackage

// ==== common/dmaConsts.svh ====
`ifndef DMA_CONSTS_SVH
`define DMA_CONSTS_SVH

// SRAM geometry
`define SRAM_DEPTH 512
`define SRAM_AW    9

// Register selectors carried in valueA[12:10]
`define SEL_MEMORY      3'd0
`define SEL_BUS_ADDR    3'd1
`define SEL_MEM_ADDR    3'd2
`define SEL_BLOCK_SIZE  3'd3
`define SEL_BURST_SIZE  3'd4
`define SEL_CTRL_STATUS 3'd5

// Commands in valueB[1:0] on a control write
// Read block moves bus data into the SRAM, write block the other way
`define CTRL_READ_BLOCK  2'd1
`define CTRL_WRITE_BLOCK 2'd2

`endif
